// File: Bender.yml
package:
  name: video_path

export_include_dirs:
  - logic

sources:
  - logic/video_pkg.sv
  - logic/pattern_gen.sv
  - logic/pixel_fifo.sv
  - logic/video_timing.sv
  - logic/video_out.sv
  - logic/wb_regs.sv
  - logic/video_top.sv
  - target: test
    files:
      - verification/video_properties.sv
      - verification/video_tb.sv

// File: flist.f
+incdir+logic
logic/video_pkg.sv
logic/pattern_gen.sv
logic/pixel_fifo.sv
logic/video_timing.sv
logic/video_out.sv
logic/wb_regs.sv
logic/video_top.sv
verification/video_properties.sv
verification/video_tb.sv

// File: logic/pattern_gen.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module pattern_gen (
	input  logic                    wb_clk_o,
	input  logic                    rst_n_i,
	input  logic                    en_i,
	output video_pkg::stream_beat_t beat_o,
	output logic                    valid_o,
	input  logic                    ready_i
);
	import video_pkg::*;

	coord_t     x;
	coord_t     y;
	frame_cnt_t frame;
	logic       xfer;

	assign valid_o = en_i;
	assign xfer    = valid_o && ready_i;

	// red = x, green = y, blue = frame index
	assign beat_o.pixel = {x, y, frame};
	assign beat_o.sof   = (x == '0) && (y == '0);
	assign beat_o.eol   = (x == coord_t'(`VIDEO_H_ACTIVE - 1));

	always_ff @(posedge wb_clk_o or negedge rst_n_i) begin
		if (!rst_n_i) begin
			x     <= '0;
			y     <= '0;
			frame <= '0;
		end else if (!en_i) begin
			x     <= '0;
			y     <= '0;
			frame <= '0;
		end else if (xfer) begin
			if (beat_o.eol) begin
				x <= '0;
				if (y == coord_t'(`VIDEO_V_ACTIVE - 1)) begin
					y     <= '0;
					frame <= frame + 1'b1;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

endmodule

// File: logic/pixel_fifo.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module pixel_fifo (
	input  logic                    wb_clk_o,
	input  logic                    rst_n_i,
	input  video_pkg::stream_beat_t beat_i,
	input  logic                    valid_i,
	output logic                    ready_o,
	output video_pkg::stream_beat_t beat_o,
	output logic                    valid_o,
	input  logic                    ready_i
);
	import video_pkg::*;

	localparam int DEPTH = `VIDEO_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	stream_beat_t     mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign ready_o = (count != CNT_W'(DEPTH));
	assign valid_o = (count != '0);
	assign push    = valid_i && ready_o;
	assign pop     = valid_o && ready_i;

	// Head of queue is read straight from storage
	assign beat_o = mem[rd_ptr];

	always_ff @(posedge wb_clk_o) begin
		if (push)
			mem[wr_ptr] <= beat_i;
	end

	always_ff @(posedge wb_clk_o or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ----------------------------------------------------------------------
// Video geometry, in pixel clocks and lines
// ----------------------------------------------------------------------

// Horizontal timing with the sync pulse first in each line
`define VIDEO_H_ACTIVE   16
`define VIDEO_H_FRONT    2
`define VIDEO_H_SYNC     4
`define VIDEO_H_BACK     2

// Vertical timing with the sync lines first in each frame
`define VIDEO_V_ACTIVE   8
`define VIDEO_V_FRONT    1
`define VIDEO_V_SYNC     2
`define VIDEO_V_BACK     1

// Stream buffer entries
`define VIDEO_FIFO_DEPTH 32

// ----------------------------------------------------------------------
// Register map with the page in adr[7:6]
// ----------------------------------------------------------------------

`define WB_PAGE_GPIO     2'd1
`define WB_PAGE_VIDEO    2'd2

`define GPIO_LED_INIT    4'b0101

`endif

// File: logic/video_out.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_out (
	input  logic                    wb_clk_o,
	input  logic                    rst_n_i,
	input  logic                    en_i,
	input  video_pkg::stream_beat_t beat_i,
	input  logic                    valid_i,
	output logic                    ready_o,
	output video_pkg::video_bus_t   video_o,
	output logic                    frame_done_o,
	output logic                    underflow_o
);
	import video_pkg::*;

	localparam int FRAME_PIX = `VIDEO_H_ACTIVE * `VIDEO_V_ACTIVE;
	localparam int PIX_W     = $clog2(FRAME_PIX);

	logic             t_vsync;
	logic             t_hsync;
	logic             t_de;
	logic             t_sof;
	logic             aligned;
	logic             sof_pending;
	logic             lock;
	logic             last_pix;
	logic [PIX_W-1:0] pix_cnt;

	video_timing u_video_timing (
		.wb_clk_o (wb_clk_o),
		.rst_n_i  (rst_n_i),
		.en_i     (en_i),
		.vsync_o  (t_vsync),
		.hsync_o  (t_hsync),
		.de_o     (t_de),
		.sof_o    (t_sof)
	);

	// ------------------------------------------------------------------
	// Stream alignment
	// ------------------------------------------------------------------

	// Lock only between frame start and the first active pixel
	assign lock     = !aligned && (t_sof || sof_pending) && !t_de && valid_i && beat_i.sof;
	assign last_pix = t_de && (pix_cnt == PIX_W'(FRAME_PIX - 1));

	// Drop beats up to the next frame start beat while unaligned
	assign ready_o = aligned ? t_de : (en_i && !beat_i.sof);

	always_ff @(posedge wb_clk_o or negedge rst_n_i) begin
		if (!rst_n_i) begin
			aligned      <= 1'b0;
			sof_pending  <= 1'b0;
			pix_cnt      <= '0;
			video_o      <= '0;
			frame_done_o <= 1'b0;
			underflow_o  <= 1'b0;
		end else if (!en_i) begin
			aligned      <= 1'b0;
			sof_pending  <= 1'b0;
			pix_cnt      <= '0;
			video_o      <= '0;
			frame_done_o <= 1'b0;
			underflow_o  <= 1'b0;
		end else begin
			if (lock)
				aligned <= 1'b1;
			if (t_de)
				sof_pending <= 1'b0;
			else if (t_sof)
				sof_pending <= 1'b1;
			if (t_sof)
				pix_cnt <= '0;
			else if (t_de)
				pix_cnt <= pix_cnt + 1'b1;

			// Output bus lags the timing by one cycle
			video_o.vsync <= t_vsync;
			video_o.hsync <= t_hsync;
			video_o.de    <= t_de;
			video_o.pixel <= (t_de && aligned && valid_i) ? beat_i.pixel : '0;
			underflow_o   <= t_de && aligned && !valid_i;
			frame_done_o  <= aligned && last_pix;
		end
	end

endmodule

// File: logic/video_pkg.sv
package video_pkg;

	typedef logic [23:0] pixel_t;
	typedef logic [7:0]  coord_t;
	typedef logic [7:0]  frame_cnt_t;
	typedef logic [7:0]  wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  led_t;

	// One pixel of the stream with its framing flags
	typedef struct packed {
		pixel_t pixel;
		logic   sof;
		logic   eol;
	} stream_beat_t;

	typedef struct packed {
		wb_adr_t    adr;
		wb_dat_t    dat;
		logic       we;
		logic [3:0] sel;
		logic       stb;
	} wb_req_t;

	typedef struct packed {
		wb_dat_t dat;
		logic    ack;
	} wb_rsp_t;

	typedef struct packed {
		logic   vsync;
		logic   hsync;
		logic   de;
		pixel_t pixel;
	} video_bus_t;

	typedef enum logic [1:0] {SYNC, BACK, ACTIVE, FRONT} timing_state_t;

endpackage

// File: logic/video_timing.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_timing (
	input  logic wb_clk_o,
	input  logic rst_n_i,
	input  logic en_i,
	output logic vsync_o,
	output logic hsync_o,
	output logic de_o,
	output logic sof_o
);
	import video_pkg::*;

	localparam int V_FIRST = `VIDEO_V_SYNC + `VIDEO_V_BACK;
	localparam int V_TOTAL = V_FIRST + `VIDEO_V_ACTIVE + `VIDEO_V_FRONT;

	timing_state_t h_state;
	timing_state_t h_state_nxt;
	coord_t        h_cnt;
	coord_t        h_len;
	coord_t        v_line;
	logic          h_last;

	// Length and successor of each horizontal phase
	always_comb begin
		h_len       = coord_t'(`VIDEO_H_FRONT);
		h_state_nxt = SYNC;
		case (h_state)
			SYNC: begin
				h_len       = coord_t'(`VIDEO_H_SYNC);
				h_state_nxt = BACK;
			end
			BACK: begin
				h_len       = coord_t'(`VIDEO_H_BACK);
				h_state_nxt = ACTIVE;
			end
			ACTIVE: begin
				h_len       = coord_t'(`VIDEO_H_ACTIVE);
				h_state_nxt = FRONT;
			end
			default: begin
				h_len       = coord_t'(`VIDEO_H_FRONT);
				h_state_nxt = SYNC;
			end
		endcase
	end

	assign h_last = (h_cnt == h_len - 1'b1);

	always_ff @(posedge wb_clk_o or negedge rst_n_i) begin
		if (!rst_n_i) begin
			h_state <= SYNC;
			h_cnt   <= '0;
			v_line  <= '0;
		end else if (!en_i) begin
			h_state <= SYNC;
			h_cnt   <= '0;
			v_line  <= '0;
		end else if (h_last) begin
			h_state <= h_state_nxt;
			h_cnt   <= '0;
			if (h_state == FRONT)
				v_line <= (v_line == coord_t'(V_TOTAL - 1)) ? '0 : v_line + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign hsync_o = en_i && (h_state == SYNC);
	assign vsync_o = en_i && (v_line < coord_t'(`VIDEO_V_SYNC));
	assign de_o    = en_i && (h_state == ACTIVE) && (v_line >= coord_t'(V_FIRST))
	                 && (v_line < coord_t'(V_FIRST + `VIDEO_V_ACTIVE));
	assign sof_o   = en_i && (h_state == SYNC) && (h_cnt == '0) && (v_line == '0);

endmodule

// File: logic/video_top.sv
`timescale 1ns/1ns

module video_top (
	input  logic                  wb_clk_o,
	input  logic                  rst_n_i,
	input  video_pkg::wb_req_t    wb_req_i,
	output video_pkg::wb_rsp_t    wb_rsp_o,
	output video_pkg::led_t       led_o,
	output video_pkg::video_bus_t video_o
);
	import video_pkg::*;

	logic         video_en;
	logic         frame_done;
	logic         underflow;
	stream_beat_t gen_beat;
	logic         gen_valid;
	logic         gen_ready;
	stream_beat_t fifo_beat;
	logic         fifo_valid;
	logic         fifo_ready;

	wb_regs u_wb_regs (
		.wb_clk_o     (wb_clk_o),
		.rst_n_i      (rst_n_i),
		.wb_req_i     (wb_req_i),
		.wb_rsp_o     (wb_rsp_o),
		.led_o        (led_o),
		.video_en_o   (video_en),
		.frame_done_i (frame_done),
		.underflow_i  (underflow)
	);

	// ------------------------------------------------------------------
	// Video path
	// ------------------------------------------------------------------

	pattern_gen u_pattern_gen (
		.wb_clk_o (wb_clk_o),
		.rst_n_i  (rst_n_i),
		.en_i     (video_en),
		.beat_o   (gen_beat),
		.valid_o  (gen_valid),
		.ready_i  (gen_ready)
	);

	pixel_fifo u_pixel_fifo (
		.wb_clk_o (wb_clk_o),
		.rst_n_i  (rst_n_i),
		.beat_i   (gen_beat),
		.valid_i  (gen_valid),
		.ready_o  (gen_ready),
		.beat_o   (fifo_beat),
		.valid_o  (fifo_valid),
		.ready_i  (fifo_ready)
	);

	video_out u_video_out (
		.wb_clk_o     (wb_clk_o),
		.rst_n_i      (rst_n_i),
		.en_i         (video_en),
		.beat_i       (fifo_beat),
		.valid_i      (fifo_valid),
		.ready_o      (fifo_ready),
		.video_o      (video_o),
		.frame_done_o (frame_done),
		.underflow_o  (underflow)
	);

endmodule

// File: logic/wb_regs.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module wb_regs (
	input  logic               wb_clk_o,
	input  logic               rst_n_i,
	input  video_pkg::wb_req_t wb_req_i,
	output video_pkg::wb_rsp_t wb_rsp_o,
	output video_pkg::led_t    led_o,
	output logic               video_en_o,
	input  logic               frame_done_i,
	input  logic               underflow_i
);
	import video_pkg::*;

	logic [1:0] page;
	logic [5:0] word;
	logic       access;
	logic       wr_b0;
	logic       sel_led;
	logic       sel_ctrl;
	logic       sel_stat;
	logic       ack_q;
	logic       underflow_q;
	frame_cnt_t frame_cnt;
	wb_dat_t    rd_dat;
	wb_dat_t    dat_q;

	// ------------------------------------------------------------------
	// Page and word decode
	// ------------------------------------------------------------------

	assign page     = wb_req_i.adr[7:6];
	assign word     = wb_req_i.adr[5:0];
	assign access   = wb_req_i.stb && !ack_q;
	assign wr_b0    = access && wb_req_i.we && wb_req_i.sel[0];
	assign sel_led  = (page == `WB_PAGE_GPIO) && (word == 6'd0);
	assign sel_ctrl = (page == `WB_PAGE_VIDEO) && (word == 6'd0);
	assign sel_stat = (page == `WB_PAGE_VIDEO) && (word == 6'd1);

	// Unmapped words fall through as zero
	always_comb begin
		rd_dat = '0;
		if (sel_led)
			rd_dat[3:0] = led_o;
		if (sel_ctrl)
			rd_dat[0] = video_en_o;
		if (sel_stat) begin
			rd_dat[0]    = underflow_q;
			rd_dat[15:8] = frame_cnt;
		end
	end

	always_ff @(posedge wb_clk_o or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q       <= 1'b0;
			dat_q       <= '0;
			led_o       <= `GPIO_LED_INIT;
			video_en_o  <= 1'b0;
			underflow_q <= 1'b0;
			frame_cnt   <= '0;
		end else begin
			ack_q <= access;
			if (access)
				dat_q <= rd_dat;
			if (wr_b0 && sel_led)
				led_o <= wb_req_i.dat[3:0];
			if (wr_b0 && sel_ctrl)
				video_en_o <= wb_req_i.dat[0];
			// New underflow wins over a clear in the same cycle
			if (underflow_i)
				underflow_q <= 1'b1;
			else if (wr_b0 && sel_stat && wb_req_i.dat[0])
				underflow_q <= 1'b0;
			if (frame_done_i)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = dat_q;

endmodule

// File: verification/video_properties.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_properties (
	input logic                  wb_clk_o,
	input logic                  rst_n_i,
	input video_pkg::video_bus_t video_i,
	input logic                  stb_i,
	input logic                  ack_i
);
	import video_pkg::*;

	// Blanked cycles carry no pixel data
	data_blank: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		!video_i.de |-> (video_i.pixel == '0))
		else $error("pixel data nonzero while de is low");

	hsync_width: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		$rose(video_i.hsync) |-> video_i.hsync [*`VIDEO_H_SYNC] ##1 !video_i.hsync)
		else $error("hsync pulse width differs from the sync length");

	// Registered ack follows a strobe
	ack_after_stb: assert property (@(posedge wb_clk_o) disable iff (!rst_n_i)
		ack_i |-> $past(stb_i))
		else $error("ack without a preceding strobe");

endmodule

bind video_out video_properties u_video_properties (
	.wb_clk_o (wb_clk_o),
	.rst_n_i  (rst_n_i),
	.video_i  (video_o),
	.stb_i    (1'b0),
	.ack_i    (1'b0)
);

bind wb_regs video_properties u_video_properties (
	.wb_clk_o (wb_clk_o),
	.rst_n_i  (rst_n_i),
	.video_i  ('0),
	.stb_i    (wb_req_i.stb),
	.ack_i    (wb_rsp_o.ack)
);

// File: verification/video_tb.sv
`timescale 1ns/1ns
`include "video_consts.svh"

module video_tb;
	import video_pkg::*;

	localparam int LINE_CYCLES  = `VIDEO_H_ACTIVE + `VIDEO_H_FRONT + `VIDEO_H_SYNC
	                              + `VIDEO_H_BACK;
	localparam int V_TOTAL      = `VIDEO_V_ACTIVE + `VIDEO_V_FRONT + `VIDEO_V_SYNC
	                              + `VIDEO_V_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * V_TOTAL;
	localparam int N_LED_WRITES = 24;
	localparam int N_FRAMES     = 3;
	localparam int ACK_LIMIT    = 16;
	localparam int TIMEOUT_CYCLES = 3 + 140 + N_LED_WRITES * 8
	                                + (N_FRAMES + 2) * FRAME_CYCLES + 1000;

	localparam wb_adr_t ADR_LED  = {`WB_PAGE_GPIO, 6'd0};
	localparam wb_adr_t ADR_CTRL = {`WB_PAGE_VIDEO, 6'd0};
	localparam wb_adr_t ADR_STAT = {`WB_PAGE_VIDEO, 6'd1};

	logic        wb_clk_o;
	logic        rst_n_i;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	led_t        led;
	video_bus_t  video;
	logic [31:0] lfsr_state;
	int          cycle_cnt;

	video_top u_video_top (
		.wb_clk_o (wb_clk_o),
		.rst_n_i  (rst_n_i),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp),
		.led_o    (led),
		.video_o  (video)
	);

	initial begin
		wb_clk_o = 1'b0;
		forever #20 wb_clk_o = ~wb_clk_o;
	end

	// Run limit
	always @(posedge wb_clk_o) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_on_error("simulation ran past its cycle limit");
	end

	// ----------------------------------------------------------------------
	// Reporting and compare tasks
	// ----------------------------------------------------------------------

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
		if (exp !== act)
			stop_on_error($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_led(input string name, input led_t exp, input led_t act);
		if (exp !== act)
			stop_on_error($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (exp !== act)
			stop_on_error($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_video(input string name, input video_bus_t exp, input video_bus_t act);
		if (exp !== act)
			stop_on_error($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
			stop_on_error($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// ----------------------------------------------------------------------
	// Wishbone master
	// ----------------------------------------------------------------------

	task automatic wb_cycle(input wb_adr_t adr, input wb_dat_t dat, input logic we,
	                        input logic [3:0] sel, output wb_dat_t rd);
		int waited;
		waited = 0;
		@(negedge wb_clk_o);
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.we  = we;
		wb_req.sel = sel;
		wb_req.stb = 1'b1;
		@(negedge wb_clk_o);
		while (!wb_rsp.ack) begin
			waited++;
			if (waited > ACK_LIMIT)
				stop_on_error($sformatf("no Wishbone ack for address %h", adr));
			@(negedge wb_clk_o);
		end
		rd = wb_rsp.dat;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat, input logic [3:0] sel);
		wb_dat_t unused;
		wb_cycle(adr, dat, 1'b1, sel, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t rd);
		wb_cycle(adr, '0, 1'b0, 4'hf, rd);
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------

	task automatic reset_defaults();
		wb_dat_t rd;
		check_led("reset led port", `GPIO_LED_INIT, led);
		wb_read(ADR_LED, rd);
		check_dat("reset led register", {28'h0, `GPIO_LED_INIT}, rd);
		wb_read(ADR_CTRL, rd);
		check_dat("reset video control", '0, rd);
		wb_read(ADR_STAT, rd);
		check_dat("reset video status", '0, rd);
		repeat (100) begin
			@(negedge wb_clk_o);
			check_video("idle video output", '0, video);
		end
	endtask

	task automatic led_writes();
		int          i;
		logic [31:0] dat;
		logic [31:0] sel;
		led_t        exp_led;
		wb_dat_t     rd;
		exp_led = `GPIO_LED_INIT;
		for (i = 0; i < N_LED_WRITES; i++) begin
			rand_bits(32, dat);
			rand_bits(4, sel);
			wb_write(ADR_LED, dat, sel[3:0]);
			// LED bits live in byte 0 only
			if (sel[0])
				exp_led = dat[3:0];
			wb_read(ADR_LED, rd);
			check_dat("led readback", {28'h0, exp_led}, rd);
			check_led("led port", exp_led, led);
		end
	endtask

	task automatic unmapped_reads();
		wb_dat_t rd;
		led_t    led_before;
		led_before = led;
		wb_write(8'hc0, {28'hfff_ffff, ~led_before}, 4'hf);
		check_led("led after unmapped write", led_before, led);
		wb_read(8'h00, rd);
		check_dat("unmapped page 0", '0, rd);
		wb_read(8'h15, rd);
		check_dat("unmapped page 0 word", '0, rd);
		wb_read(8'hc0, rd);
		check_dat("unmapped page 3", '0, rd);
		wb_read(8'hff, rd);
		check_dat("unmapped page 3 top", '0, rd);
		wb_read({`WB_PAGE_GPIO, 6'd5}, rd);
		check_dat("unmapped gpio word", '0, rd);
	endtask

	task automatic wait_vsync_rise();
		int   waited;
		logic prev_vs;
		waited  = 0;
		prev_vs = video.vsync;
		@(negedge wb_clk_o);
		while (!(video.vsync && !prev_vs)) begin
			waited++;
			if (waited > FRAME_CYCLES)
				stop_on_error("vsync never started after video enable");
			prev_vs = video.vsync;
			@(negedge wb_clk_o);
		end
	endtask

	task automatic frame_timing(input int n_frames);
		int         fr;
		int         cycles;
		int         lines;
		int         de_cnt;
		int         vs_cnt;
		int         hs_len;
		logic       prev_vs;
		video_bus_t v;
		pixel_t     exp_pix;
		wait_vsync_rise();
		for (fr = 0; fr < n_frames; fr++) begin
			cycles = 0;
			lines  = 0;
			de_cnt = 0;
			vs_cnt = 0;
			hs_len = 0;
			do begin
				v = video;
				if (v.vsync)
					vs_cnt++;
				if (v.hsync) begin
					if (hs_len == 0)
						lines++;
					hs_len++;
				end else if (hs_len != 0) begin
					check_count("hsync width", `VIDEO_H_SYNC, hs_len);
					hs_len = 0;
				end
				if (v.de) begin
					// Raster position from the de count and the frame number in blue
					exp_pix = {coord_t'(de_cnt % `VIDEO_H_ACTIVE),
					           coord_t'(de_cnt / `VIDEO_H_ACTIVE), frame_cnt_t'(fr)};
					check_pixel("frame pixel", exp_pix, v.pixel);
					de_cnt++;
				end
				prev_vs = v.vsync;
				@(negedge wb_clk_o);
				cycles++;
				if (cycles > 2 * FRAME_CYCLES)
					stop_on_error("vsync did not return within two frame periods");
			end while (!(video.vsync && !prev_vs));
			check_count("frame length", FRAME_CYCLES, cycles);
			check_count("lines per frame", V_TOTAL, lines);
			check_count("vsync cycles", `VIDEO_V_SYNC * LINE_CYCLES, vs_cnt);
			check_count("de cycles", `VIDEO_H_ACTIVE * `VIDEO_V_ACTIVE, de_cnt);
		end
	endtask

	task automatic frame_status();
		wb_dat_t rd;
		wb_read(ADR_STAT, rd);
		check_dat("video status", {16'h0, frame_cnt_t'(N_FRAMES), 8'h00}, rd);
		wb_read(ADR_CTRL, rd);
		check_dat("video control", 32'h1, rd);
	endtask

	initial begin
		rst_n_i    = 1'b0;
		wb_req     = '0;
		cycle_cnt  = 0;
		lfsr_state = 32'h27e0_1993;
		repeat (3) @(negedge wb_clk_o);
		rst_n_i = 1'b1;

		reset_defaults();
		led_writes();
		unmapped_reads();
		wb_write(ADR_CTRL, 32'h1, 4'h1);
		frame_timing(N_FRAMES);
		frame_status();

		$display("Verification passed");
		$finish;
	end

endmodule
